// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - rtl/cache_pkg.sv
  - rtl/cache_line_store.sv
  - rtl/cache_tag_store.sv
  - rtl/cache_ctrl.sv
  - rtl/mem_delayed.sv
  - rtl/cache_top.sv
  - target: test
    files:
      - tests/tb_cache_top.sv

// ==== project.f ====
rtl/cache_pkg.sv
rtl/cache_line_store.sv
rtl/cache_tag_store.sv
rtl/cache_ctrl.sv
rtl/mem_delayed.sv
rtl/cache_top.sv
tests/tb_cache_top.sv

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  cache_pkg::wb_req_t             wb_req,
    output cache_pkg::wb_rsp_t             wb_rsp,
    input  logic                           hit,
    input  logic [cache_pkg::DATA_W-1:0]   line_rdata,
    output logic                           tag_update,
    output logic                           line_we,
    output cache_pkg::mem_req_t            mem_req,
    input  cache_pkg::mem_rsp_t            mem_rsp
);
    import cache_pkg::*;

    ctrl_state_t       state;
    logic              issued;
    logic              rsp_ack;
    logic [DATA_W-1:0] rsp_dat;
    logic [ADDR_W-1:0] req_adr;
    logic [DATA_W-1:0] req_dat;
    logic              start;
    logic              hit_done;
    logic              fill_done;
    logic              wr_done;
    logic              rd_go;
    logic              wr_go;

    assign start     = (state == IDLE) && wb_req.cyc && wb_req.stb;
    // The first cycle of FILL is the tag lookup. A hit never touches memory.
    assign hit_done  = (state == FILL) && !issued && hit;
    assign rd_go     = (state == FILL) && !issued && !hit;
    assign wr_go     = (state == WRITE_THROUGH) && !issued;
    assign fill_done = (state == FILL) && issued && mem_rsp.ack;
    assign wr_done   = (state == WRITE_THROUGH) && issued && mem_rsp.ack;

    always_comb begin
        mem_req.rd   = rd_go;
        mem_req.wr   = wr_go;
        mem_req.addr = req_adr;
        // During a fill the memory read data goes to the line store.
        mem_req.data = (state == FILL) ? mem_rsp.data : req_dat;
    end

    assign tag_update = fill_done;
    assign line_we    = fill_done || (wr_go && hit);   // Write hit updates the line at issue.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            issued  <= 1'b0;
            rsp_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    issued <= 1'b0;
                    if (start) begin
                        state <= wb_req.we ? WRITE_THROUGH : FILL;
                    end
                end
                FILL: begin
                    if (rd_go) begin
                        issued <= 1'b1;
                    end
                    if (hit_done || fill_done) begin
                        rsp_ack <= 1'b1;
                        state   <= RESPOND;
                    end
                end
                WRITE_THROUGH: begin
                    if (wr_go) begin
                        issued <= 1'b1;
                    end
                    if (wr_done) begin
                        rsp_ack <= 1'b1;
                        state   <= RESPOND;
                    end
                end
                RESPOND: begin
                    rsp_ack <= 1'b0;   // Ack is high for this one cycle only.
                    state   <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_adr <= wb_req.adr;
            req_dat <= wb_req.dat;
        end
        if (hit_done) begin
            rsp_dat <= line_rdata;
        end else if (fill_done) begin
            rsp_dat <= mem_rsp.data;
        end
    end

    assign wb_rsp = '{ack: rsp_ack, dat: rsp_dat};

    // The master must still hold its cycle when the cache answers.
    a_ack_in_cycle : assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("bus acknowledge outside of an active bus cycle");

    // Memory has finished the previous operation before a new one starts.
    a_req_not_busy : assert property (@(posedge clk) disable iff (rst)
        (mem_req.rd || mem_req.wr) |-> !mem_rsp.busy)
        else $error("memory request issued while the memory is busy");

endmodule

`default_nettype wire

// ==== rtl/cache_line_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_line_store (
    input  logic                          clk,
    input  logic [cache_pkg::INDEX_W-1:0] index,
    input  logic                          we,
    input  logic [cache_pkg::DATA_W-1:0]  wdata,
    output logic [cache_pkg::DATA_W-1:0]  rdata
);
    import cache_pkg::*;

    logic [DATA_W-1:0] lines [LINES];

    // The read is combinational so a hit is answered in one cycle.
    assign rdata = lines[index];

    always_ff @(posedge clk) begin
        if (we) begin
            lines[index] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int ADDR_W    = 10;
    localparam int DATA_W    = 32;
    localparam int LINES     = 64;
    localparam int INDEX_W   = 6;
    localparam int TAG_W     = 2;
    localparam int INDEX_LSB = 2;                     // Word offset inside the byte address.
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;   // Tag sits above the line index.
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;
    localparam int MEM_DELAY = 16;
    localparam int DELAY_W   = $clog2(MEM_DELAY);

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;   // Also the word written into the line store.
    } mem_req_t;

    typedef struct packed {
        logic              busy;
        logic              ack;
        logic [DATA_W-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic              en;
        logic [MEM_AW-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_preload_t;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        WRITE_THROUGH,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/cache_tag_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_tag_store (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cache_pkg::ADDR_W-1:0] adr,
    input  logic                         update,
    output logic                         hit
);
    import cache_pkg::*;

    logic [LINES-1:0]   valid;
    logic [TAG_W-1:0]   tags [LINES];
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;

    assign index = adr[TAG_LSB-1:INDEX_LSB];
    assign tag   = adr[ADDR_W-1:TAG_LSB];

    assign hit = valid[index] && (tags[index] == tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;   // Every line starts out empty.
        end else if (update) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            tags[index] <= tag;
        end
    end

    // Only a read miss refills a line.
    a_update_on_miss : assert property (@(posedge clk) disable iff (rst)
        update |-> !hit)
        else $error("line refilled although the lookup hit");

    // A refilled line hits while the same address stays on the lookup port.
    a_hit_after_update : assert property (@(posedge clk) disable iff (rst)
        update ##1 $stable(adr) |-> hit)
        else $error("refilled line does not hit");

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::wb_req_t      wb_req,
    output cache_pkg::wb_rsp_t      wb_rsp,
    input  cache_pkg::mem_preload_t preload
);
    import cache_pkg::*;

    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    logic              hit;
    logic              tag_update;
    logic              line_we;
    logic [DATA_W-1:0] line_rdata;

    cache_ctrl i_cache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .hit        (hit),
        .line_rdata (line_rdata),
        .tag_update (tag_update),
        .line_we    (line_we),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    // Both stores look up the address latched by the controller.
    cache_tag_store i_cache_tag_store (
        .clk    (clk),
        .rst    (rst),
        .adr    (mem_req.addr),
        .update (tag_update),
        .hit    (hit)
    );

    cache_line_store i_cache_line_store (
        .clk   (clk),
        .index (mem_req.addr[TAG_LSB-1:INDEX_LSB]),
        .we    (line_we),
        .wdata (mem_req.data),
        .rdata (line_rdata)
    );

    mem_delayed i_mem_delayed (
        .clk     (clk),
        .rst     (rst),
        .req     (mem_req),
        .rsp     (mem_rsp),
        .preload (preload)
    );

endmodule

`default_nettype wire

// ==== rtl/mem_delayed.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_delayed (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::mem_req_t     req,
    output cache_pkg::mem_rsp_t     rsp,
    input  cache_pkg::mem_preload_t preload
);
    import cache_pkg::*;

    localparam logic [DELAY_W-1:0] DELAY_INIT = DELAY_W'(MEM_DELAY - 1);

    logic [DATA_W-1:0]  mem [MEM_WORDS];
    logic               pend_rd;
    logic               pend_wr;
    logic [ADDR_W-1:0]  pend_addr;
    logic [DATA_W-1:0]  pend_data;
    logic [DELAY_W-1:0] cnt;
    logic               busy;
    logic               ack;
    logic [DATA_W-1:0]  rd_data;
    logic [MEM_AW-1:0]  pend_word;
    logic               accept;
    logic               finish;

    assign pend_word = pend_addr[ADDR_W-1:INDEX_LSB];
    assign accept    = !preload.en && !pend_rd && !pend_wr && (req.rd || req.wr);
    assign finish    = !preload.en && (pend_rd || pend_wr) && (cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_rd <= 1'b0;
            pend_wr <= 1'b0;
            busy    <= 1'b0;
            ack     <= 1'b0;
            cnt     <= '0;
        end else if (preload.en) begin
            ack <= 1'b0;   // Preload freezes any pending operation.
        end else if (pend_rd || pend_wr) begin
            if (cnt == '0) begin
                ack     <= 1'b1;
                busy    <= 1'b0;
                pend_rd <= 1'b0;
                pend_wr <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (req.wr) begin
            pend_wr <= 1'b1;
            busy    <= 1'b1;
            ack     <= 1'b0;
            cnt     <= DELAY_INIT;
        end else if (req.rd) begin
            pend_rd <= 1'b1;
            busy    <= 1'b1;
            ack     <= 1'b0;
            cnt     <= DELAY_INIT;
        end else begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_addr <= req.addr;
            pend_data <= req.data;
        end
        if (preload.en) begin
            mem[preload.addr] <= preload.data;
        end else if (finish && pend_wr) begin
            mem[pend_word] <= pend_data;
        end
        if (finish && pend_rd) begin
            rd_data <= mem[pend_word];   // Valid in the ack cycle.
        end
    end

    assign rsp = '{busy: busy, ack: ack, data: rd_data};

    a_rd_wr_exclusive : assert property (@(posedge clk) disable iff (rst)
        !(req.rd && req.wr))
        else $error("read and write requested in the same cycle");

endmodule

`default_nettype wire

// ==== tests/tb_cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cache_top;
    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 4 * MEM_DELAY;
    localparam int HIT_LATENCY    = 1;
    localparam int MISS_LATENCY   = MEM_DELAY + 2;
    localparam int XFERS_BEFORE   = 250;   // Random transfers before the mid-test reset.
    localparam int XFERS_AFTER    = 50;

    logic         clk;
    logic         rst;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    mem_preload_t preload;

    logic [DATA_W-1:0]  mem_model  [MEM_WORDS];
    logic [LINES-1:0]   line_valid;
    logic [TAG_W-1:0]   line_tag   [LINES];
    logic [INDEX_W-1:0] index_pool [4];
    integer             seed;
    int                 data_errors;
    int                 latency_errors;
    int                 timeout_errors;

    cache_top i_cache_top (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .preload (preload)
    );

    always #50 clk = ~clk;

    task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp,
                             input logic [ADDR_W-1:0] adr);
        if (got !== exp) begin
            data_errors++;
            $display({"mismatch at %0t: read of 0x%03h gave ack %0b data 0x%08h, ",
                      "expected %0b 0x%08h"},
                     $time, adr, got.ack, got.dat, exp.ack, exp.dat);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input logic we,
                                 input logic [ADDR_W-1:0] adr);
        if (got != exp) begin
            latency_errors++;
            $display("mismatch at %0t: %s of 0x%03h acknowledged after %0d cycles, expected %0d",
                     $time, we ? "write" : "read", adr, got, exp);
        end
    endtask

    // Starts and ends on a falling edge. Cycles count from the edge that samples the request.
    task automatic bus_transfer(input logic we, input logic [ADDR_W-1:0] adr,
                                input logic [DATA_W-1:0] dat, output wb_rsp_t rsp,
                                output int cycles, output logic timed_out);
        int   waited;
        logic seen;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        rsp    = '0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
            if (wb_rsp.ack) begin
                rsp  = wb_rsp;
                seen = 1'b1;
            end
        end
        cycles    = waited - 1;
        timed_out = !seen;
        if (!seen) begin
            timeout_errors++;
            $display("no acknowledge from the cache before the timeout (address 0x%03h)", adr);
        end
        @(negedge clk);   // The master keeps stb through the ack cycle.
        wb_req = '0;
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] adr);
        wb_rsp_t            got;
        wb_rsp_t            exp;
        int                 cycles;
        logic               timed_out;
        logic               hit;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic [DATA_W-1:0]  junk;
        idx  = adr[TAG_LSB-1:INDEX_LSB];
        tag  = adr[ADDR_W-1:TAG_LSB];
        hit  = line_valid[idx] && (line_tag[idx] == tag);
        junk = $random(seed);
        bus_transfer(1'b0, adr, junk, got, cycles, timed_out);
        if (!timed_out) begin
            exp.ack = 1'b1;
            exp.dat = mem_model[adr[ADDR_W-1:INDEX_LSB]];
            check_rsp(got, exp, adr);
            check_latency(cycles, hit ? HIT_LATENCY : MISS_LATENCY, 1'b0, adr);
        end
        if (!hit) begin
            line_valid[idx] = 1'b1;   // A read miss fills the line.
            line_tag[idx]   = tag;
        end
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
        wb_rsp_t got;
        int      cycles;
        logic    timed_out;
        bus_transfer(1'b1, adr, dat, got, cycles, timed_out);
        if (!timed_out) begin
            check_latency(cycles, MISS_LATENCY, 1'b1, adr);
        end
        mem_model[adr[ADDR_W-1:INDEX_LSB]] = dat;   // Write-through without allocation on a miss.
    endtask

    task automatic random_transfer();
        logic [31:0]       r;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        r   = $random(seed);
        dat = $random(seed);
        adr = {r[3:2], index_pool[r[1:0]], 2'b00};
        if (r[6:4] < 3'd3) begin
            write_word(adr, dat);
        end else begin
            read_word(adr);
        end
    endtask

    task automatic preload_memory();
        logic [DATA_W-1:0] dat;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dat          = $random(seed);
            preload.en   = 1'b1;
            preload.addr = MEM_AW'(i);
            preload.data = dat;
            mem_model[i] = dat;
            @(negedge clk);
        end
        preload = '0;
    endtask

    task automatic pulse_reset(input int cycles);
        rst = 1'b1;
        repeat (cycles) @(negedge clk);
        rst        = 1'b0;
        line_valid = '0;   // Memory contents survive a reset.
    endtask

    initial begin
        logic [31:0] r;
        seed           = 32'hac10412f;
        clk            = 1'b0;
        rst            = 1'b1;
        wb_req         = '0;
        preload        = '0;
        data_errors    = 0;
        latency_errors = 0;
        timeout_errors = 0;
        line_valid     = '0;
        for (int i = 0; i < 4; i++) begin
            r             = $random(seed);
            index_pool[i] = r[INDEX_W-1:0];
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        preload_memory();

        read_word({2'd1, 6'd10, 2'b00});   // Same index with two tags.
        read_word({2'd1, 6'd10, 2'b00});
        read_word({2'd2, 6'd10, 2'b00});
        read_word({2'd1, 6'd10, 2'b00});
        write_word({2'd3, 6'd20, 2'b00}, 32'h5a5a_0001);
        read_word({2'd3, 6'd20, 2'b00});
        write_word({2'd3, 6'd20, 2'b00}, 32'ha5a5_0002);
        read_word({2'd3, 6'd20, 2'b00});

        repeat (XFERS_BEFORE) random_transfer();
        for (int i = 0; i < 4; i++) begin
            read_word({TAG_W'(i), index_pool[i], 2'b00});   // These lines are valid at the reset.
        end
        pulse_reset(3);
        for (int i = 3; i >= 0; i--) begin
            read_word({TAG_W'(i), index_pool[i], 2'b00});
        end
        repeat (XFERS_AFTER) random_transfer();

        $display("errors: data %0d, latency %0d, timeout %0d",
                 data_errors, latency_errors, timeout_errors);
        if (data_errors == 0 && latency_errors == 0 && timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
